/* common/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// address and load/store data width
`define LSU_ADDR_W 32

// byte lanes on the memory bus, 64 bits in all
`define LSU_BUS_BYTES 8
`define LSU_BUS_W 64

// byte offset within one bus word
`define LSU_OFF_W 3

// transfer size field and response field
`define LSU_SIZE_W 3
`define LSU_RESP_W 2

// slave response for an access fault
`define LSU_RESP_FAULT 3

`endif

/* common/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

	// bit 3 set marks a store
	typedef enum logic [3:0] {
		OP_LW  = 4'h0,
		OP_LH  = 4'h1,
		OP_LHU = 4'h2,
		OP_LB  = 4'h3,
		OP_LBU = 4'h4,
		OP_SW  = 4'h8,
		OP_SH  = 4'h9,
		OP_SB  = 4'ha
	} lsu_op_e;

	// --------------------
	// request and result
	// --------------------

	typedef struct packed {
		lsu_op_e                op;
		logic [`LSU_ADDR_W-1:0] addr;
		logic [`LSU_ADDR_W-1:0] data;
	} lsu_req_t;

	// stores come back with zero data
	typedef struct packed {
		logic [`LSU_ADDR_W-1:0] data;
		logic                   fault;
	} lsu_resp_t;

	// --------------------
	// memory bus channels
	// --------------------

	// shared by ar and aw
	typedef struct packed {
		logic [`LSU_ADDR_W-1:0] addr;
		logic [`LSU_SIZE_W-1:0] size;
	} mem_a_t;

	typedef struct packed {
		logic [`LSU_BUS_W-1:0]     data;
		logic [`LSU_BUS_BYTES-1:0] strb;
	} mem_w_t;

	typedef struct packed {
		logic [`LSU_BUS_W-1:0]  data;
		logic [`LSU_RESP_W-1:0] resp;
	} mem_r_t;

	// --------------------
	// internal stages
	// --------------------

	// lane plan for one request, beats is 1 or 2
	typedef struct packed {
		lsu_op_e                   op;
		logic [`LSU_OFF_W-1:0]     offset;
		logic [1:0]                beats;
		logic [`LSU_ADDR_W-1:0]    addr0;
		logic [`LSU_ADDR_W-1:0]    addr1;
		logic [`LSU_BUS_BYTES-1:0] strb0;
		logic [`LSU_BUS_BYTES-1:0] strb1;
		logic [`LSU_SIZE_W-1:0]    size;
		logic [`LSU_BUS_W-1:0]     wdata;
	} beat_plan_t;

	// finished access, raw beats still unaligned
	typedef struct packed {
		lsu_op_e                   op;
		logic [`LSU_OFF_W-1:0]     offset;
		logic [`LSU_BUS_BYTES-1:0] strb0;
		logic [`LSU_BUS_BYTES-1:0] strb1;
		logic [`LSU_BUS_W-1:0]     data0;
		logic [`LSU_BUS_W-1:0]     data1;
		logic                      fault;
	} seq_done_t;

	function automatic logic is_store(lsu_op_e op);
		return op inside {OP_SW, OP_SH, OP_SB};
	endfunction

endpackage

/* design/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     full;
	logic     live;
	payload_t data_q;

	// goes high one cycle out of reset
	always_ff @(posedge clock) begin
		if (reset) begin
			live <= 1'b0;
		end else begin
			live <= 1'b1;
		end
	end

	// empty slot, or a full one draining this cycle
	assign in_ready = live && (!full || out_ready);

	always_ff @(posedge clock) begin
		if (reset) begin
			full <= 1'b0;
		end else if (in_valid && in_ready) begin
			full <= 1'b1;
		end else if (out_ready) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = full;
	assign out_data  = data_q;

endmodule

/* design/lane_planner.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lane_planner (
	input  lsu_pkg::lsu_req_t   req,
	output lsu_pkg::beat_plan_t plan
);

	import lsu_pkg::*;

	logic [`LSU_OFF_W-1:0]     offset;
	logic [2:0]                nbytes;
	logic [2:0]                room;
	logic                      crosses;
	logic [`LSU_ADDR_W-1:0]    next_word;
	logic [`LSU_OFF_W-1:0]     lane;
	logic [`LSU_BUS_BYTES-1:0] strb0;
	logic [`LSU_BUS_BYTES-1:0] strb1;
	logic [`LSU_BUS_W-1:0]     wdata;

	assign offset = req.addr[`LSU_OFF_W-1:0];

	always_comb begin
		case (req.op)
			OP_LW, OP_SW:         nbytes = 3'd4;
			OP_LH, OP_LHU, OP_SH: nbytes = 3'd2;
			default:              nbytes = 3'd1;
		endcase
	end

	// bytes left before the next 4-byte boundary
	assign room      = 3'd4 - {1'b0, req.addr[1:0]};
	assign crosses   = nbytes > room;
	assign next_word = {req.addr[`LSU_ADDR_W-1:2] + 1'b1, 2'b00};

	// --------------------
	// lanes and data
	// --------------------

	// byte i lands on lane (addr + i) mod 8
	always_comb begin
		strb0 = '0;
		strb1 = '0;
		wdata = '0;
		lane  = offset;
		for (int i = 0; i < 4; i++) begin
			lane = offset + 3'(i);
			wdata[lane*8 +: 8] = req.data[i*8 +: 8];
			if (i < nbytes) begin
				if (i < room) begin
					strb0[lane] = 1'b1;
				end else begin
					strb1[lane] = 1'b1;
				end
			end
		end
	end

	// --------------------
	// plan
	// --------------------

	always_comb begin
		plan        = '0;
		plan.op     = req.op;
		plan.offset = offset;
		plan.beats  = crosses ? 2'd2 : 2'd1;
		plan.addr0  = req.addr;
		plan.addr1  = next_word;
		plan.strb0  = strb0;
		plan.strb1  = strb1;
		plan.wdata  = wdata;
		// size follows the op, not the split
		case (nbytes)
			3'd4:    plan.size = `LSU_SIZE_W'(2);
			3'd2:    plan.size = `LSU_SIZE_W'(1);
			default: plan.size = `LSU_SIZE_W'(0);
		endcase
	end

endmodule

/* lsu/bus_sequencer.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module bus_sequencer (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   plan_valid,
	output logic                   plan_ready,
	input  lsu_pkg::beat_plan_t    plan,
	output logic                   ar_valid,
	input  logic                   ar_ready,
	output lsu_pkg::mem_a_t        ar,
	input  logic                   r_valid,
	output logic                   r_ready,
	input  lsu_pkg::mem_r_t        r,
	output logic                   aw_valid,
	input  logic                   aw_ready,
	output lsu_pkg::mem_a_t        aw,
	output logic                   w_valid,
	input  logic                   w_ready,
	output lsu_pkg::mem_w_t        w,
	input  logic                   b_valid,
	output logic                   b_ready,
	input  logic [`LSU_RESP_W-1:0] b_resp,
	output logic                   done_valid,
	input  logic                   done_ready,
	output lsu_pkg::seq_done_t     done
);

	import lsu_pkg::*;

	typedef enum logic [1:0] {
		R_IDLE,
		R_ADDR,
		R_DATA
	} rd_state_e;

	typedef enum logic [1:0] {
		W_IDLE,
		W_SEND,
		W_RESP
	} wr_state_e;

	rd_state_e             rd_state;
	wr_state_e             wr_state;
	beat_plan_t            plan_q;
	logic                  second_q;
	logic                  aw_pend;
	logic                  w_pend;
	logic                  done_q;
	logic                  fault_q;
	logic [`LSU_BUS_W-1:0] data0_q;
	logic [`LSU_BUS_W-1:0] data1_q;
	logic                  take;
	logic                  r_fire;
	logic                  b_fire;
	logic                  r_fault;
	logic                  b_fault;
	logic                  last_beat;
	mem_a_t                beat_a;

	// new access only when both sides idle and the last one is gone
	assign plan_ready = (rd_state == R_IDLE) && (wr_state == W_IDLE)
		&& (!done_q || done_ready);
	assign take      = plan_valid && plan_ready;
	assign r_fire    = r_valid && r_ready;
	assign b_fire    = b_valid && b_ready;
	assign r_fault   = r.resp == `LSU_RESP_W'(`LSU_RESP_FAULT);
	assign b_fault   = b_resp == `LSU_RESP_W'(`LSU_RESP_FAULT);
	assign last_beat = second_q || (plan_q.beats != 2'd2);

	// --------------------
	// read FSM
	// --------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_state <= R_IDLE;
		end else begin
			case (rd_state)
				R_IDLE: begin
					if (take && !is_store(plan.op)) begin
						rd_state <= R_ADDR;
					end
				end
				R_ADDR: begin
					if (ar_ready) begin
						rd_state <= R_DATA;
					end
				end
				R_DATA: begin
					// second beat goes out right after the first response
					if (r_valid) begin
						rd_state <= last_beat ? R_IDLE : R_ADDR;
					end
				end
				default: rd_state <= R_IDLE;
			endcase
		end
	end

	// --------------------
	// write FSM
	// --------------------

	// aw and w complete on their own
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_state <= W_IDLE;
			aw_pend  <= 1'b0;
			w_pend   <= 1'b0;
		end else begin
			case (wr_state)
				W_IDLE: begin
					if (take && is_store(plan.op)) begin
						wr_state <= W_SEND;
						aw_pend  <= 1'b1;
						w_pend   <= 1'b1;
					end
				end
				W_SEND: begin
					if (aw_ready) begin
						aw_pend <= 1'b0;
					end
					if (w_ready) begin
						w_pend <= 1'b0;
					end
					if ((!aw_pend || aw_ready) && (!w_pend || w_ready)) begin
						wr_state <= W_RESP;
					end
				end
				W_RESP: begin
					if (b_valid && !last_beat) begin
						wr_state <= W_SEND;
						aw_pend  <= 1'b1;
						w_pend   <= 1'b1;
					end else if (b_valid) begin
						wr_state <= W_IDLE;
					end
				end
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// --------------------
	// beat and completion
	// --------------------

	always_ff @(posedge clock) begin
		if (reset) begin
			second_q <= 1'b0;
			done_q   <= 1'b0;
		end else begin
			if (take) begin
				second_q <= 1'b0;
			end else if ((r_fire || b_fire) && !last_beat) begin
				second_q <= 1'b1;
			end
			if ((r_fire || b_fire) && last_beat) begin
				done_q <= 1'b1;
			end else if (done_ready) begin
				done_q <= 1'b0;
			end
		end
	end

	// plan, read beats, fault over both beats
	always_ff @(posedge clock) begin
		if (take) begin
			plan_q  <= plan;
			fault_q <= 1'b0;
		end else begin
			fault_q <= fault_q | (r_fire && r_fault) | (b_fire && b_fault);
		end
		if (r_fire && !second_q) begin
			data0_q <= r.data;
		end
		if (r_fire && second_q) begin
			data1_q <= r.data;
		end
	end

	assign beat_a.addr = second_q ? plan_q.addr1 : plan_q.addr0;
	assign beat_a.size = plan_q.size;

	assign ar_valid = rd_state == R_ADDR;
	assign r_ready  = rd_state == R_DATA;
	assign ar       = beat_a;
	assign aw_valid = (wr_state == W_SEND) && aw_pend;
	assign w_valid  = (wr_state == W_SEND) && w_pend;
	assign b_ready  = wr_state == W_RESP;
	assign aw       = beat_a;
	assign w.data   = plan_q.wdata;
	assign w.strb   = second_q ? plan_q.strb1 : plan_q.strb0;

	assign done_valid   = done_q;
	assign done.op      = plan_q.op;
	assign done.offset  = plan_q.offset;
	assign done.strb0   = plan_q.strb0;
	assign done.strb1   = plan_q.strb1;
	assign done.data0   = data0_q;
	assign done.data1   = data1_q;
	assign done.fault   = fault_q;

endmodule

/* lsu/load_align.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module load_align (
	input  lsu_pkg::seq_done_t done,
	output lsu_pkg::lsu_resp_t resp
);

	import lsu_pkg::*;

	logic [3:0][7:0]        raw;
	logic [`LSU_OFF_W-1:0]  lane;
	logic [`LSU_ADDR_W-1:0] word;

	// --------------------
	// byte gather
	// --------------------

	// byte i sits on lane offset + i, in whichever beat strobed it
	always_comb begin
		raw  = '0;
		lane = done.offset;
		for (int i = 0; i < 4; i++) begin
			lane = done.offset + 3'(i);
			if (done.strb0[lane]) begin
				raw[i] = done.data0[lane*8 +: 8];
			end else if (done.strb1[lane]) begin
				raw[i] = done.data1[lane*8 +: 8];
			end
		end
	end

	// --------------------
	// extension
	// --------------------

	always_comb begin
		case (done.op)
			OP_LW:   word = raw;
			OP_LH:   word = {{16{raw[1][7]}}, raw[1], raw[0]};
			OP_LHU:  word = {16'b0, raw[1], raw[0]};
			OP_LB:   word = {{24{raw[0][7]}}, raw[0]};
			OP_LBU:  word = {24'b0, raw[0]};
			// stores return no data
			default: word = '0;
		endcase
	end

	assign resp.data  = word;
	assign resp.fault = done.fault;

endmodule

/* lsu/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top (
	input  logic                   clock,
	input  logic                   reset,
	// request port
	input  logic                   req_valid,
	output logic                   req_ready,
	input  lsu_pkg::lsu_req_t      req,
	// result port
	output logic                   resp_valid,
	input  logic                   resp_ready,
	output lsu_pkg::lsu_resp_t     resp,
	// memory bus
	output logic                   ar_valid,
	input  logic                   ar_ready,
	output lsu_pkg::mem_a_t        ar,
	input  logic                   r_valid,
	output logic                   r_ready,
	input  lsu_pkg::mem_r_t        r,
	output logic                   aw_valid,
	input  logic                   aw_ready,
	output lsu_pkg::mem_a_t        aw,
	output logic                   w_valid,
	input  logic                   w_ready,
	output lsu_pkg::mem_w_t        w,
	input  logic                   b_valid,
	output logic                   b_ready,
	input  logic [`LSU_RESP_W-1:0] b_resp
);

	import lsu_pkg::*;

	logic       plan_valid;
	logic       plan_ready;
	lsu_req_t   req_q;
	beat_plan_t plan;
	logic       done_valid;
	logic       done_ready;
	seq_done_t  done;
	lsu_resp_t  resp_d;

	// --------------------
	// request side
	// --------------------

	pipe_stage #(
		.payload_t (lsu_req_t)
	) req_stage (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (req_valid),
		.in_ready  (req_ready),
		.in_data   (req),
		.out_valid (plan_valid),
		.out_ready (plan_ready),
		.out_data  (req_q)
	);

	lane_planner lane_planner (
		.req  (req_q),
		.plan (plan)
	);

	// --------------------
	// bus side
	// --------------------

	bus_sequencer bus_sequencer (
		.clock      (clock),
		.reset      (reset),
		.plan_valid (plan_valid),
		.plan_ready (plan_ready),
		.plan       (plan),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.ar         (ar),
		.r_valid    (r_valid),
		.r_ready    (r_ready),
		.r          (r),
		.aw_valid   (aw_valid),
		.aw_ready   (aw_ready),
		.aw         (aw),
		.w_valid    (w_valid),
		.w_ready    (w_ready),
		.w          (w),
		.b_valid    (b_valid),
		.b_ready    (b_ready),
		.b_resp     (b_resp),
		.done_valid (done_valid),
		.done_ready (done_ready),
		.done       (done)
	);

	// --------------------
	// result side
	// --------------------

	load_align load_align (
		.done (done),
		.resp (resp_d)
	);

	pipe_stage #(
		.payload_t (lsu_resp_t)
	) resp_stage (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (done_valid),
		.in_ready  (done_ready),
		.in_data   (resp_d),
		.out_valid (resp_valid),
		.out_ready (resp_ready),
		.out_data  (resp)
	);

endmodule

/* verif/mem_model.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_model (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   ar_valid,
	output logic                   ar_ready,
	input  lsu_pkg::mem_a_t        ar,
	output logic                   r_valid,
	input  logic                   r_ready,
	output lsu_pkg::mem_r_t        r,
	input  logic                   aw_valid,
	output logic                   aw_ready,
	input  lsu_pkg::mem_a_t        aw,
	input  logic                   w_valid,
	output logic                   w_ready,
	input  lsu_pkg::mem_w_t        w,
	output logic                   b_valid,
	input  logic                   b_ready,
	output logic [`LSU_RESP_W-1:0] b_resp
);

	import lsu_pkg::*;

	// fault window, one bus word
	localparam logic [31:0] FAULT_LO = 32'h100;
	localparam logic [31:0] FAULT_HI = 32'h108;

	logic [7:0]  mem [0:511];
	int          seed;
	logic        rd_got;
	logic [31:0] rd_addr;
	int          rd_wait;
	logic        aw_got;
	logic        w_got;
	logic [31:0] wr_addr;
	mem_w_t      wr_beat;

	function automatic logic [7:0] fill_byte(int a);
		return 8'((a * 37) ^ (a >> 8) ^ 8'h5c);
	endfunction

	function automatic logic in_fault(logic [31:0] a);
		return (a >= FAULT_LO) && (a < FAULT_HI);
	endfunction

	// whole 8-byte word around the beat address
	function automatic mem_r_t read_beat(logic [31:0] a);
		mem_r_t      v;
		logic [31:0] base;
		base = {a[31:3], 3'b000};
		v    = '0;
		for (int k = 0; k < 8; k++) begin
			v.data[k*8 +: 8] = mem[(base + 32'(k)) & 32'h1ff];
		end
		if (in_fault(a)) begin
			v.data = '0;
			v.resp = `LSU_RESP_W'(`LSU_RESP_FAULT);
		end
		return v;
	endfunction

	task automatic write_beat(logic [31:0] a, mem_w_t wb);
		logic [31:0] base;
		base = {a[31:3], 3'b000};
		if (!in_fault(a)) begin
			for (int k = 0; k < 8; k++) begin
				if (wb.strb[k]) begin
					mem[(base + 32'(k)) & 32'h1ff] = wb.data[k*8 +: 8];
				end
			end
		end
	endtask

	// outputs change on falling edges only
	initial begin
		seed = 91683;
		for (int a = 0; a < 512; a++) begin
			mem[a] = fill_byte(a);
		end
		ar_ready = 1'b0;
		aw_ready = 1'b0;
		w_ready  = 1'b0;
		r_valid  = 1'b0;
		b_valid  = 1'b0;
		r        = '0;
		b_resp   = '0;
		rd_got   = 1'b0;
		aw_got   = 1'b0;
		w_got    = 1'b0;
		rd_wait  = 0;
		forever begin
			@(negedge clock);
			ar_ready = 1'b0;
			aw_ready = 1'b0;
			w_ready  = 1'b0;
			r_valid  = 1'b0;
			b_valid  = 1'b0;
			if (reset) begin
				rd_got = 1'b0;
				aw_got = 1'b0;
				w_got  = 1'b0;
			end else begin
				// read side
				if (rd_got) begin
					if (rd_wait > 0 || !r_ready) begin
						rd_wait = rd_wait - 1;
					end else begin
						r       = read_beat(rd_addr);
						r_valid = 1'b1;
						rd_got  = 1'b0;
					end
				end else if (ar_valid && ($random(seed) & 1)) begin
					ar_ready = 1'b1;
					rd_addr  = ar.addr;
					rd_wait  = $random(seed) & 3;
					rd_got   = 1'b1;
				end
				// write side, aw and w taken independently
				if (aw_got && w_got) begin
					if (b_ready) begin
						write_beat(wr_addr, wr_beat);
						b_resp  = in_fault(wr_addr) ? `LSU_RESP_W'(`LSU_RESP_FAULT) : '0;
						b_valid = 1'b1;
						aw_got  = 1'b0;
						w_got   = 1'b0;
					end
				end else begin
					if (aw_valid && !aw_got && ($random(seed) & 1)) begin
						aw_ready = 1'b1;
						wr_addr  = aw.addr;
						aw_got   = 1'b1;
					end
					if (w_valid && !w_got && ($random(seed) & 1)) begin
						w_ready = 1'b1;
						wr_beat = w;
						w_got   = 1'b1;
					end
				end
			end
		end
	end

endmodule

/* verif/lsu_chk.sv */
`timescale 1ns/1ps

module lsu_chk (
	input logic               clock,
	input logic               reset,
	input logic               ar_valid,
	input logic               ar_ready,
	input lsu_pkg::mem_a_t    ar,
	input logic               aw_valid,
	input logic               aw_ready,
	input lsu_pkg::mem_a_t    aw,
	input logic               w_valid,
	input logic               w_ready,
	input lsu_pkg::mem_w_t    w,
	input logic               resp_valid,
	input logic               resp_ready,
	input lsu_pkg::lsu_resp_t resp
);

	// assertion failures so far
	int fails = 0;

	// --------------------
	// valid held until taken
	// --------------------

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			$error("ar dropped or changed before handshake");
			fails++;
		end

	aw_hold: assert property (@(posedge clock) disable iff (reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin
			$error("aw dropped or changed before handshake");
			fails++;
		end

	w_hold: assert property (@(posedge clock) disable iff (reset)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else begin
			$error("w dropped or changed before handshake");
			fails++;
		end

	resp_hold: assert property (@(posedge clock) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp))
		else begin
			$error("result dropped or changed before handshake");
			fails++;
		end

	// --------------------
	// channel rules
	// --------------------

	one_addr: assert property (@(posedge clock) disable iff (reset)
		!(ar_valid && aw_valid))
		else begin
			$error("read and write address valid together");
			fails++;
		end

	strb_set: assert property (@(posedge clock) disable iff (reset)
		w_valid |-> w.strb != '0)
		else begin
			$error("write beat with no strobes");
			fails++;
		end

endmodule

bind lsu_top lsu_chk lsu_chk_i (
	.clock      (clock),
	.reset      (reset),
	.ar_valid   (ar_valid),
	.ar_ready   (ar_ready),
	.ar         (ar),
	.aw_valid   (aw_valid),
	.aw_ready   (aw_ready),
	.aw         (aw),
	.w_valid    (w_valid),
	.w_ready    (w_ready),
	.w          (w),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready),
	.resp       (resp)
);

/* verif/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb;

	import lsu_pkg::*;

	localparam int TIMEOUT = 1000;

	logic                   clock;
	logic                   reset;
	logic                   req_valid;
	logic                   req_ready;
	lsu_req_t               req;
	logic                   resp_valid;
	logic                   resp_ready;
	lsu_resp_t              resp;
	logic                   ar_valid;
	logic                   ar_ready;
	mem_a_t                 ar;
	logic                   r_valid;
	logic                   r_ready;
	mem_r_t                 r;
	logic                   aw_valid;
	logic                   aw_ready;
	mem_a_t                 aw;
	logic                   w_valid;
	logic                   w_ready;
	mem_w_t                 w;
	logic                   b_valid;
	logic                   b_ready;
	logic [`LSU_RESP_W-1:0] b_resp;
	logic [7:0]             shadow [0:511];
	int                     seed;
	mem_w_t                 wbeats[$];
	mem_a_t                 waddrs[$];
	mem_a_t                 raddrs[$];

	lsu_top lsu_top_i (.*);

	mem_model mem_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// bus beats as they complete
	always @(posedge clock) begin
		if (!reset) begin
			if (w_valid && w_ready) wbeats.push_back(w);
			if (aw_valid && aw_ready) waddrs.push_back(aw);
			if (ar_valid && ar_ready) raddrs.push_back(ar);
		end
	end

	// --------------------
	// reference rules
	// --------------------

	function automatic logic [7:0] fill_byte(int a);
		return 8'((a * 37) ^ (a >> 8) ^ 8'h5c);
	endfunction

	function automatic logic in_window(logic [31:0] a);
		return (a >= 32'h100) && (a < 32'h108);
	endfunction

	function automatic int byte_count(lsu_op_e op);
		case (op)
			OP_LW, OP_SW:         return 4;
			OP_LH, OP_LHU, OP_SH: return 2;
			default:              return 1;
		endcase
	endfunction

	function automatic lsu_resp_t predict(lsu_req_t q);
		logic [3:0][7:0] b;
		logic [31:0]     a;
		lsu_resp_t       p;
		b       = '0;
		p.fault = 1'b0;
		for (int i = 0; i < byte_count(q.op); i++) begin
			a = q.addr + 32'(i);
			if (in_window(a)) begin
				p.fault = 1'b1;
			end else begin
				b[i] = shadow[a & 32'h1ff];
			end
		end
		case (q.op)
			OP_LW:   p.data = b;
			OP_LH:   p.data = {{16{b[1][7]}}, b[1], b[0]};
			OP_LHU:  p.data = {16'h0, b[1], b[0]};
			OP_LB:   p.data = {{24{b[0][7]}}, b[0]};
			OP_LBU:  p.data = {24'h0, b[0]};
			default: p.data = '0;
		endcase
		return p;
	endfunction

	task automatic apply_store(lsu_req_t q);
		logic [31:0] a;
		if (q.op inside {OP_SW, OP_SH, OP_SB}) begin
			for (int i = 0; i < byte_count(q.op); i++) begin
				a = q.addr + 32'(i);
				if (!in_window(a)) shadow[a & 32'h1ff] = q.data[i*8 +: 8];
			end
		end
	endtask

	// write beat from lane rules, beat 0 or 1
	function automatic mem_w_t expect_wbeat(lsu_req_t q, int beat);
		mem_w_t      e;
		logic [63:0] tmp;
		int          off;
		int          lane;
		off    = int'(q.addr[2:0]);
		tmp    = {32'h0, q.data};
		e.data = (tmp << (off * 8)) | (tmp >> (64 - off * 8));
		e.strb = '0;
		for (int i = 0; i < byte_count(q.op); i++) begin
			lane = (off + i) % 8;
			if (((int'(q.addr[1:0]) + i) < 4) == (beat == 0)) e.strb[lane] = 1'b1;
		end
		return e;
	endfunction

	// address beat from lane rules, beat 0 or 1
	function automatic mem_a_t expect_abeat(lsu_req_t q, int beat);
		mem_a_t e;
		if (beat == 0) begin
			e.addr = q.addr;
		end else begin
			e.addr = (q.addr & ~32'h3) + 32'h4;
		end
		// size is log2 of the access bytes
		e.size = `LSU_SIZE_W'($clog2(byte_count(q.op)));
		return e;
	endfunction

	// --------------------
	// checks and driving
	// --------------------

	task automatic fail_now(string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_resp(string name, lsu_resp_t exp, lsu_resp_t act);
		if (exp !== act) begin
			$display("** Error %s: expected data %h fault %b, actual data %h fault %b",
				name, exp.data, exp.fault, act.data, act.fault);
			fail_now("result mismatch");
		end
	endtask

	task automatic check_wbeat(string name, mem_w_t exp, mem_w_t act);
		if (exp !== act) begin
			$display("** Error %s: expected data %h strb %b, actual data %h strb %b",
				name, exp.data, exp.strb, act.data, act.strb);
			fail_now("write beat mismatch");
		end
	endtask

	task automatic check_abeat(string name, mem_a_t exp, mem_a_t act);
		if (exp !== act) begin
			$display("** Error %s: expected addr %h size %0d, actual addr %h size %0d",
				name, exp.addr, exp.size, act.addr, act.size);
			fail_now("address beat mismatch");
		end
	endtask

	// called on a falling edge, returns on one
	task automatic send_req(lsu_req_t q);
		int t;
		t         = 0;
		req       = q;
		req_valid = 1'b1;
		while (!req_ready) begin
			@(negedge clock);
			t++;
			if (t > TIMEOUT) fail_now("request was never accepted");
		end
		@(negedge clock);
		req_valid = 1'b0;
	endtask

	task automatic take_resp(output lsu_resp_t got);
		int t;
		t          = 0;
		resp_ready = 1'b1;
		while (!resp_valid) begin
			@(negedge clock);
			t++;
			if (t > TIMEOUT) fail_now("no result arrived");
		end
		got = resp;
		@(negedge clock);
		resp_ready = 1'b0;
	endtask

	task automatic access(string name, lsu_op_e op, logic [31:0] addr, logic [31:0] data);
		lsu_req_t  q;
		lsu_resp_t exp;
		lsu_resp_t got;
		q.op   = op;
		q.addr = addr;
		q.data = data;
		exp    = predict(q);
		send_req(q);
		take_resp(got);
		check_resp(name, exp, got);
		apply_store(q);
	endtask

	// one load, then its read beats against the lane rules
	task automatic load_with_beats(string name, lsu_op_e op, logic [31:0] addr);
		lsu_req_t q;
		int       want;
		q.op   = op;
		q.addr = addr;
		q.data = '0;
		want   = (int'(addr[1:0]) + byte_count(op) > 4) ? 2 : 1;
		raddrs.delete();
		access(name, op, addr, 32'h0);
		if (raddrs.size() != want) begin
			fail_now("load used the wrong number of read beats");
		end
		for (int j = 0; j < want; j++) begin
			check_abeat(name, expect_abeat(q, j), raddrs[j]);
		end
	endtask

	// --------------------
	// directed tests
	// --------------------

	task automatic aligned_ops();
		access("aligned sw", OP_SW, 32'h40, 32'h8badf00d);
		access("aligned sh", OP_SH, 32'h44, 32'h1234a5c3);
		access("aligned sb", OP_SB, 32'h46, 32'h0000009e);
		access("aligned lw", OP_LW, 32'h40, 32'h0);
		access("aligned lh", OP_LH, 32'h44, 32'h0);
		access("aligned lhu", OP_LHU, 32'h44, 32'h0);
		access("aligned lb", OP_LB, 32'h46, 32'h0);
		access("aligned lbu", OP_LBU, 32'h46, 32'h0);
		access("aligned lb low", OP_LB, 32'h40, 32'h0);
	endtask

	task automatic split_word_store();
		lsu_req_t  q;
		lsu_resp_t got;
		q.op   = OP_SW;
		q.addr = 32'h55;
		q.data = 32'h11223344;
		wbeats.delete();
		waddrs.delete();
		access("split sw", q.op, q.addr, q.data);
		if (wbeats.size() != 2 || waddrs.size() != 2) begin
			fail_now("split sw did not produce exactly two write beats");
		end
		check_abeat("split sw addr 0", expect_abeat(q, 0), waddrs[0]);
		check_abeat("split sw addr 1", expect_abeat(q, 1), waddrs[1]);
		check_wbeat("split sw beat 0", expect_wbeat(q, 0), wbeats[0]);
		check_wbeat("split sw beat 1", expect_wbeat(q, 1), wbeats[1]);
		q.op = OP_LW;
		send_req(q);
		take_resp(got);
		check_resp("split lw", lsu_resp_t'{data: 32'h11223344, fault: 1'b0}, got);
	endtask

	task automatic split_half_loads();
		logic [31:0] offs [4];
		offs = '{32'h63, 32'h67, 32'h61, 32'h65};
		access("split sh", OP_SH, 32'h67, 32'h000080f1);
		foreach (offs[k]) begin
			load_with_beats("half lh", OP_LH, offs[k]);
			load_with_beats("half lhu", OP_LHU, offs[k]);
		end
	endtask

	task automatic held_results();
		lsu_req_t  q [3];
		lsu_resp_t exp [3];
		lsu_resp_t got;
		int        t;
		q[0] = '{op: OP_LW, addr: 32'h40, data: 32'h0};
		q[1] = '{op: OP_LBU, addr: 32'h56, data: 32'h0};
		q[2] = '{op: OP_LH, addr: 32'h63, data: 32'h0};
		resp_ready = 1'b0;
		for (int k = 0; k < 3; k++) begin
			exp[k] = predict(q[k]);
			send_req(q[k]);
		end
		t = 0;
		while (req_ready) begin
			@(negedge clock);
			t++;
			if (t > TIMEOUT) fail_now("req_ready never dropped under back-pressure");
		end
		for (int k = 0; k < 3; k++) begin
			take_resp(got);
			check_resp("backpressure", exp[k], got);
		end
	endtask

	task automatic fault_accesses();
		access("fault lw first", OP_LW, 32'h100, 32'h0);
		access("fault lw second", OP_LW, 32'hfe, 32'h0);
		access("fault sw second", OP_SW, 32'hfd, 32'hcafe5a17);
		access("fault sb", OP_SB, 32'h104, 32'h000000ee);
		// memory just outside the window
		access("fault lw below", OP_LW, 32'hfc, 32'h0);
		access("fault lw above", OP_LW, 32'h108, 32'h0);
		access("fault lw low", OP_LW, 32'hf8, 32'h0);
	endtask

	task automatic random_ops();
		lsu_op_e     op;
		logic [31:0] addr;
		logic [31:0] data;
		for (int n = 0; n < 200; n++) begin
			case ($random(seed) & 7)
				0:       op = OP_LW;
				1:       op = OP_LH;
				2:       op = OP_LHU;
				3:       op = OP_LB;
				4:       op = OP_LBU;
				5:       op = OP_SW;
				6:       op = OP_SH;
				default: op = OP_SB;
			endcase
			addr = 32'h20 + 32'($random(seed) & 8'h3f);
			data = $random(seed);
			access("random", op, addr, data);
		end
	endtask

	initial begin
		seed       = 91683;
		reset      = 1'b1;
		req_valid  = 1'b0;
		req        = '0;
		resp_ready = 1'b0;
		for (int a = 0; a < 512; a++) begin
			shadow[a] = fill_byte(a);
		end
		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		aligned_ops();
		split_word_store();
		split_half_loads();
		held_results();
		fault_accesses();
		random_ops();
		if (lsu_top_i.lsu_chk_i.fails == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			fail_now("a bus protocol assertion failed");
		end
	end

endmodule

/* tb.f */
+incdir+common
common/lsu_pkg.sv
design/pipe_stage.sv
design/lane_planner.sv
lsu/bus_sequencer.sv
lsu/load_align.sv
lsu/lsu_top.sv
verif/mem_model.sv
verif/lsu_chk.sv
verif/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module lsu_tb -o lsu_sim

# the simulator may stop with an error status, the search below decides
out=$(./obj_dir/lsu_sim) || true
echo "$out"
echo "$out" | grep -q "Testbench passed"
